//--- Bender.yml
package:
  name: mcp1611_datapath

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mcp1611_pkg.sv
      - rtl/reg_select.sv
      - rtl/register_file.sv
      - rtl/operand_stage.sv
      - rtl/execute_stage.sv
      - rtl/mcp1611_datapath.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clock.sv
      - tb/mcp1611_assert.sv
      - tb/tb_mcp1611.sv

//--- files.f
+incdir+rtl
rtl/mcp1611_pkg.sv
rtl/reg_select.sv
rtl/register_file.sv
rtl/operand_stage.sv
rtl/execute_stage.sv
rtl/mcp1611_datapath.sv
tb/tb_clock.sv
tb/mcp1611_assert.sv
tb/tb_mcp1611.sv

//--- rtl/execute_stage.sv
// single-cycle PLA ALU with plain carry in; no shift, borrow inversion or split writes
`timescale 1ns/1ns
`include "mcp1611_params.svh"

module execute_stage
(
   input  logic                   clk,
   input  logic                   rst,
   input  mcp1611_pkg::data_t     fa,        // operand A
   input  mcp1611_pkg::data_t     fb,        // operand B
   input  mcp1611_pkg::alu_fn_t   fn,        // PLA function
   input  logic                   cin_q,     // carry into bit 0
   input  mcp1611_pkg::reg_idx_t  dst_idx,   // port A register
   input  logic                   wr_q,
   input  logic                   flag_q,
   input  logic                   out_q,
   output logic                   wr,        // write strobe, also the bypass valid
   output mcp1611_pkg::reg_idx_t  wr_idx,
   output mcp1611_pkg::data_t     wr_data,
   output mcp1611_pkg::psw_t      psw,       // status flags
   output mcp1611_pkg::word_t     ad_out,    // {fb, fa} latch
   output logic                   ad_stb     // one-cycle output strobe
);

mcp1611_pkg::data_t x;          // propagate terms
mcp1611_pkg::data_t y;          // generate terms
mcp1611_pkg::data_t co;         // carry out of each bit
mcp1611_pkg::data_t sum;        // ALU result
mcp1611_pkg::psw_t  flags;      // flags of this result

// per-bit function selected by the operand bit pair
always_comb
begin
   for (int i = 0; i < `MCP_DATA_W; i++)
   begin
      x[i] = fa[i] ? (fb[i] ? fn[6] : fn[5]) : (fb[i] ? fn[4] : fn[3]);
      y[i] = fa[i] ? (fb[i] ? fn[0] : fn[1]) : (fb[i] ? fn[2] : 1'b0);
   end
end

// ripple chain
always_comb
begin
   logic carry;

   carry = cin_q;
   for (int i = 0; i < `MCP_DATA_W; i++)
   begin
      sum[i] = carry ^ x[i];
      co[i]  = y[i] | (x[i] & carry);
      carry  = co[i];
   end
end

always_comb
begin
   flags.c = co[7];
   flags.v = co[6] ^ co[7];
   flags.z = (sum == '0);
   flags.n = sum[7];
   flags.h = co[3];                 // half carry
end

assign wr      = wr_q;
assign wr_idx  = dst_idx;
assign wr_data = sum;

always_ff @(posedge clk)
begin
   if (rst)
      psw <= '0;
   else if (flag_q)
      psw <= flags;
end

always_ff @(posedge clk)
begin
   if (out_q)
      ad_out <= {fb, fa};           // high byte is port B
end

always_ff @(posedge clk)
begin
   if (rst)
      ad_stb <= 1'b0;
   else
      ad_stb <= out_q;             // rises on the same edge as the latch
end

endmodule

//--- rtl/mcp1611_datapath.sv
// decoded controls drive this top directly; ops may issue every clock with no back-pressure
`timescale 1ns/1ns

module mcp1611_datapath
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  op_valid,   // op strobe
   input  mcp1611_pkg::word_t    mir,        // microinstruction
   input  mcp1611_pkg::alu_fn_t  alu_fn,     // PLA function
   input  logic                  cin,
   input  logic                  wr_en,      // write back to port A
   input  logic                  flag_we,    // update PSW
   input  logic                  out_req,    // output {fb, fa}
   input  logic                  g_load,     // G load strobe
   input  mcp1611_pkg::bank_t    g_data,
   output mcp1611_pkg::psw_t     psw,
   output mcp1611_pkg::word_t    ad_out,
   output logic                  ad_stb
);

mcp1611_pkg::reg_idx_t ra_idx;
mcp1611_pkg::reg_idx_t rb_idx;
mcp1611_pkg::data_t    ra;
mcp1611_pkg::data_t    rb;
mcp1611_pkg::data_t    fa;
mcp1611_pkg::data_t    fb;
mcp1611_pkg::alu_fn_t  fn;
logic                  cin_q;
mcp1611_pkg::reg_idx_t dst_idx;
logic                  wr_q;
logic                  flag_q;
logic                  out_q;
logic                  wr;           // write port, shared with the bypass
mcp1611_pkg::reg_idx_t wr_idx;
mcp1611_pkg::data_t    wr_data;

operand_stage u_operand
(
   .clk(clk),             .rst(rst),
   .op_valid(op_valid),   .mir(mir),
   .alu_fn(alu_fn),       .cin(cin),
   .wr_en(wr_en),         .flag_we(flag_we),
   .out_req(out_req),     .g_load(g_load),
   .g_data(g_data),       .ra(ra),
   .rb(rb),               .fwd_wr(wr),
   .fwd_idx(wr_idx),      .fwd_data(wr_data),
   .ra_idx(ra_idx),       .rb_idx(rb_idx),
   .fa(fa),               .fb(fb),
   .fn(fn),               .cin_q(cin_q),
   .dst_idx(dst_idx),     .wr_q(wr_q),
   .flag_q(flag_q),       .out_q(out_q)
);

register_file u_regs
(
   .clk(clk),             .rst(rst),
   .ra_idx(ra_idx),       .rb_idx(rb_idx),
   .ra(ra),               .rb(rb),
   .wr(wr),               .wr_idx(wr_idx),
   .wr_data(wr_data)
);

execute_stage u_execute
(
   .clk(clk),             .rst(rst),
   .fa(fa),               .fb(fb),
   .fn(fn),               .cin_q(cin_q),
   .dst_idx(dst_idx),     .wr_q(wr_q),
   .flag_q(flag_q),       .out_q(out_q),
   .wr(wr),               .wr_idx(wr_idx),
   .wr_data(wr_data),     .psw(psw),
   .ad_out(ad_out),       .ad_stb(ad_stb)
);

endmodule

//--- rtl/mcp1611_params.svh
// fixed widths of the data chip; the selector decode assumes 26 registers and a 3-bit bank
`ifndef MCP1611_PARAMS_SVH
`define MCP1611_PARAMS_SVH

// byte datapath
`define MCP_DATA_W     8

// registers 0..11 banked, 12..25 fixed
`define MCP_REG_COUNT  26

// microinstruction selector field
`define MCP_SEL_W      4

// G register
`define MCP_BANK_W     3

// PLA function bits, propagate 6..3 and generate 2..0
`define MCP_FN_W       7

`endif

//--- rtl/mcp1611_pkg.sv
// shared datapath types; the params header must be on the include path
package mcp1611_pkg;

`include "mcp1611_params.svh"

// register and operand byte
typedef logic [`MCP_DATA_W-1:0] data_t;

// microinstruction and AD output word
typedef logic [2*`MCP_DATA_W-1:0] word_t;

// physical register index, only 0..25 are used
typedef logic [$clog2(`MCP_REG_COUNT)-1:0] reg_idx_t;

// selector field of the microinstruction
typedef logic [`MCP_SEL_W-1:0] sel_t;

// G bank register value
typedef logic [`MCP_BANK_W-1:0] bank_t;

// PLA function bits
typedef logic [`MCP_FN_W-1:0] alu_fn_t;

// status flags, c sits in bit 0 as on the chip
typedef struct packed
{
   logic h;                        // half carry out of bit 3
   logic n;                        // result bit 7
   logic z;                        // result is zero
   logic v;                        // overflow
   logic c;                        // carry out of bit 7
} psw_t;

endpackage

//--- rtl/operand_stage.sv
// issue stage; a bank load takes effect for ops after the edge that samples it
`timescale 1ns/1ns

module operand_stage
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   op_valid,  // op strobe
   input  mcp1611_pkg::word_t     mir,       // microinstruction
   input  mcp1611_pkg::alu_fn_t   alu_fn,    // PLA function
   input  logic                   cin,       // carry into bit 0
   input  logic                   wr_en,     // write back to port A register
   input  logic                   flag_we,   // update PSW
   input  logic                   out_req,   // present operands on AD
   input  logic                   g_load,    // G load strobe
   input  mcp1611_pkg::bank_t     g_data,    // new bank
   input  mcp1611_pkg::data_t     ra,        // register file port A
   input  mcp1611_pkg::data_t     rb,        // register file port B
   input  logic                   fwd_wr,    // write in flight
   input  mcp1611_pkg::reg_idx_t  fwd_idx,   // its target
   input  mcp1611_pkg::data_t     fwd_data,  // its result
   output mcp1611_pkg::reg_idx_t  ra_idx,
   output mcp1611_pkg::reg_idx_t  rb_idx,
   output mcp1611_pkg::data_t     fa,        // ALU operand A
   output mcp1611_pkg::data_t     fb,        // ALU operand B
   output mcp1611_pkg::alu_fn_t   fn,
   output logic                   cin_q,
   output mcp1611_pkg::reg_idx_t  dst_idx,   // write-back target
   output logic                   wr_q,
   output logic                   flag_q,
   output logic                   out_q
);

mcp1611_pkg::bank_t g;          // bank register
mcp1611_pkg::data_t ra_fwd;     // port A after bypass
mcp1611_pkg::data_t rb_fwd;     // port B after bypass
mcp1611_pkg::data_t fb_sel;     // register or literal

reg_select sel_a
(
   .sel(mir[3:0]),
   .bank(g),
   .idx(ra_idx)
);

reg_select sel_b
(
   .sel(mir[7:4]),
   .bank(g),
   .idx(rb_idx)
);

// the register file still holds the old byte at this edge
assign ra_fwd = (fwd_wr && fwd_idx == ra_idx) ? fwd_data : ra;
assign rb_fwd = (fwd_wr && fwd_idx == rb_idx) ? fwd_data : rb;
assign fb_sel = mir[15] ? rb_fwd : mir[11:4];     // literal when bit 15 low

always_ff @(posedge clk)
begin
   if (rst)
      g <= '0;
   else if (g_load)
      g <= g_data;
end

always_ff @(posedge clk)
begin
   if (op_valid)
   begin
      fa      <= ra_fwd;
      fb      <= fb_sel;
      fn      <= alu_fn;
      cin_q   <= cin;
      dst_idx <= ra_idx;
   end
end

always_ff @(posedge clk)
begin
   if (rst)
   begin
      wr_q   <= 1'b0;
      flag_q <= 1'b0;
      out_q  <= 1'b0;
   end
   else
   begin
      wr_q   <= op_valid & wr_en;
      flag_q <= op_valid & flag_we;
      out_q  <= op_valid & out_req;
   end
end

endmodule

//--- rtl/reg_select.sv
// combinational decode where only codes 0 and 1 follow the bank and all others are fixed
`timescale 1ns/1ns

module reg_select
(
   input  mcp1611_pkg::sel_t     sel,     // selector field
   input  mcp1611_pkg::bank_t    bank,    // G register
   output mcp1611_pkg::reg_idx_t idx      // physical register
);

always_comb
begin
   if (sel[3:1] == 3'b000)
   begin
      // banked pair, the last two banks alias the fixed 12..15
      if (bank < 3'd6)
         idx = {1'b0, bank, sel[0]};        // 2g or 2g+1
      else if (bank == 3'd6)
         idx = sel[0] ? 5'd14 : 5'd15;
      else
         idx = sel[0] ? 5'd12 : 5'd13;
   end
   else
   begin
      // 15..12 give 12..15, 11..2 give 16..25
      idx = 5'd27 - {1'b0, sel};
   end
end

endmodule

//--- rtl/register_file.sv
// 26x8 storage cleared by reset; indexes above 25 are never produced by reg_select
`timescale 1ns/1ns
`include "mcp1611_params.svh"

module register_file
(
   input  logic                  clk,
   input  logic                  rst,
   input  mcp1611_pkg::reg_idx_t ra_idx,    // port A read index
   input  mcp1611_pkg::reg_idx_t rb_idx,    // port B read index
   output mcp1611_pkg::data_t    ra,        // port A data
   output mcp1611_pkg::data_t    rb,        // port B data
   input  logic                  wr,        // write strobe
   input  mcp1611_pkg::reg_idx_t wr_idx,    // write index
   input  mcp1611_pkg::data_t    wr_data    // write data
);

mcp1611_pkg::data_t mem [0:`MCP_REG_COUNT-1];   // general registers

// asynchronous reads, old value while a write is pending
assign ra = mem[ra_idx];
assign rb = mem[rb_idx];

always_ff @(posedge clk)
begin
   if (rst)
   begin
      for (int i = 0; i < `MCP_REG_COUNT; i++)
         mem[i] <= '0;
   end
   else if (wr)
   begin
      mem[wr_idx] <= wr_data;
   end
end

endmodule

//--- tb/mcp1611_assert.sv
// timing rules for ad_stb and psw assume ops are sampled two edges before their effect shows
`timescale 1ns/1ns

module mcp1611_assert
(
   input logic              clk,
   input logic              rst,
   input logic              op_valid,
   input logic              out_req,
   input logic              flag_we,
   input logic              ad_stb,
   input mcp1611_pkg::psw_t psw
);

int unsigned fail_count = 0;         // read by the testbench

// strobe only follows an op that asked for output
stb_after_req: assert property (@(posedge clk) disable iff (rst)
   ad_stb |-> $past(op_valid && out_req, 2))
else
begin
   fail_count++;
   $error("ad_stb high without an out_req op two edges earlier");
end

// flags move only after an op with flag_we
psw_after_flag_we: assert property (@(posedge clk) disable iff (rst)
   $changed(psw) |-> $past(op_valid && flag_we, 2))
else
begin
   fail_count++;
   $error("psw changed without a flag_we op two edges earlier");
end

endmodule

//--- tb/tb_clock.sv
// free-running clock with a 4 ns period; the first rising edge comes at 2 ns
`timescale 1ns/1ns

module tb_clock
(
   output logic clk
);

initial
begin
   clk = 1'b0;
   forever #2 clk = ~clk;          // half period
end

endmodule

//--- tb/tb_mcp1611.sv
// expected values come from a model of the selector and PLA rules run over the whole table first
`timescale 1ns/1ns
`include "mcp1611_params.svh"

module tb_mcp1611;

typedef struct
{
   logic                 op_valid;
   mcp1611_pkg::word_t   mir;
   mcp1611_pkg::alu_fn_t fn;
   logic                 cin;
   logic                 wr_en;
   logic                 flag_we;
   logic                 out_req;
   logic                 g_load;
   mcp1611_pkg::bank_t   g_data;
   logic                 check;      // compare ad_out for this op
   mcp1611_pkg::word_t   exp_word;   // {fb, fa}
   mcp1611_pkg::psw_t    exp_psw;    // flags once this op retires
} entry_t;

localparam mcp1611_pkg::alu_fn_t PASS_B = 7'b1010000;   // x = b, no generate
localparam mcp1611_pkg::alu_fn_t ADD    = 7'b0110001;   // x = a ^ b, y = a & b

logic                 clk;
logic                 rst;
logic                 op_valid;
mcp1611_pkg::word_t   mir;
mcp1611_pkg::alu_fn_t alu_fn;
logic                 cin;
logic                 wr_en;
logic                 flag_we;
logic                 out_req;
logic                 g_load;
mcp1611_pkg::bank_t   g_data;
mcp1611_pkg::psw_t    psw;
mcp1611_pkg::word_t   ad_out;
logic                 ad_stb;

entry_t             tbl[$];
mcp1611_pkg::data_t model_regs [0:`MCP_REG_COUNT-1];
mcp1611_pkg::bank_t model_bank;
mcp1611_pkg::psw_t  model_psw;
int                 err_count = 0;
int                 cycle_count = 0;
int                 cycle_limit = 0;
bit                 limit_ready = 1'b0;

tb_clock clk_gen
(
   .clk(clk)
);

mcp1611_datapath UUT
(
   .clk(clk),             .rst(rst),
   .op_valid(op_valid),   .mir(mir),
   .alu_fn(alu_fn),       .cin(cin),
   .wr_en(wr_en),         .flag_we(flag_we),
   .out_req(out_req),     .g_load(g_load),
   .g_data(g_data),       .psw(psw),
   .ad_out(ad_out),       .ad_stb(ad_stb)
);

bind mcp1611_datapath mcp1611_assert u_assert
(
   .clk(clk),             .rst(rst),
   .op_valid(op_valid),   .out_req(out_req),
   .flag_we(flag_we),     .ad_stb(ad_stb),
   .psw(psw)
);

task automatic stop_on_error();
   err_count++;
   $display("Finished with errors");
   $fatal(1, "run stopped at the first error");
endtask

task automatic check_word(input string name, input mcp1611_pkg::word_t got,
                          input mcp1611_pkg::word_t exp);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
   end
endtask

task automatic check_psw(input string name, input mcp1611_pkg::psw_t got,
                         input mcp1611_pkg::psw_t exp);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t ns: %s (hnzvc) = %b, expected %b", $time, name, got, exp);
      stop_on_error();
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_on_error();
   end
endtask

// banked codes 0 and 1, then the fixed codes
function automatic mcp1611_pkg::reg_idx_t map_sel(input mcp1611_pkg::sel_t sel,
                                                  input mcp1611_pkg::bank_t bank);
   case (sel)
      4'd0: return (bank < 3'd6) ? 5'(2 * bank) : ((bank == 3'd6) ? 5'd15 : 5'd13);
      4'd1: return (bank < 3'd6) ? 5'(2 * bank + 1) : ((bank == 3'd6) ? 5'd14 : 5'd12);
      4'd12, 4'd13, 4'd14, 4'd15: return 5'(12 + (15 - int'(sel)));
      default: return 5'(16 + (11 - int'(sel)));
   endcase
endfunction

task automatic model_alu(input mcp1611_pkg::data_t a, input mcp1611_pkg::data_t b,
                         input mcp1611_pkg::alu_fn_t f, input logic c_in,
                         output mcp1611_pkg::data_t res, output mcp1611_pkg::psw_t fl);
   logic [8:0] c;                    // c[i+1] is the carry out of bit i
   logic       x;
   logic       y;
   int         k;
   c[0] = c_in;
   for (int i = 0; i < 8; i++)
   begin
      k = {a[i], b[i]};              // 3 both set, 2 a only, 1 b only
      x = f[3 + k];
      y = (k == 0) ? 1'b0 : f[3 - k];
      res[i] = c[i] ^ x;
      c[i + 1] = y | (x & c[i]);
   end
   fl.c = c[8];
   fl.v = c[7] ^ c[8];
   fl.z = (res == '0);
   fl.n = res[7];
   fl.h = c[4];
endtask

task automatic add_entry(input logic valid, input mcp1611_pkg::word_t m,
                         input mcp1611_pkg::alu_fn_t f, input logic c_in, input logic we,
                         input logic fwe, input logic oreq, input logic gl,
                         input mcp1611_pkg::bank_t gd);
   entry_t e;
   e.op_valid = valid;
   e.mir      = m;
   e.fn       = f;
   e.cin      = c_in;
   e.wr_en    = we;
   e.flag_we  = fwe;
   e.out_req  = oreq;
   e.g_load   = gl;
   e.g_data   = gd;
   e.check    = valid & oreq;
   tbl.push_back(e);
endtask

task automatic load_lit(input mcp1611_pkg::sel_t dst, input mcp1611_pkg::data_t lit);
   add_entry(1'b1, {4'h0, lit, dst}, PASS_B, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
endtask

task automatic read_pair(input mcp1611_pkg::sel_t sa, input mcp1611_pkg::sel_t sb);
   add_entry(1'b1, {1'b1, 7'h00, sb, sa}, PASS_B, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 3'd0);
endtask

task automatic add_lit(input mcp1611_pkg::sel_t dst, input mcp1611_pkg::data_t lit,
                       input logic c_in);
   add_entry(1'b1, {4'h0, lit, dst}, ADD, c_in, 1'b1, 1'b1, 1'b1, 1'b0, 3'd0);
endtask

task automatic add_flag_case(input mcp1611_pkg::sel_t dst, input mcp1611_pkg::data_t a,
                             input mcp1611_pkg::data_t b, input logic c_in);
   load_lit(dst, a);
   add_lit(dst, b, c_in);
   read_pair(dst, dst);
endtask

task automatic build_table();
   mcp1611_pkg::bank_t banks [4];
   banks = '{3'd0, 3'd3, 3'd6, 3'd7};
   read_pair(4'd0, 4'd1);                    // registers straight out of reset
   read_pair(4'd12, 4'd2);
   load_lit(4'd0, 8'h3C);
   load_lit(4'd1, 8'hA5);
   read_pair(4'd0, 4'd1);
   load_lit(4'd2, 8'h7F);
   load_lit(4'd12, 8'h80);
   load_lit(4'd15, 8'h01);
   load_lit(4'd11, 8'hFF);
   read_pair(4'd2, 4'd12);
   read_pair(4'd15, 4'd11);
   add_flag_case(4'd3, 8'h7F, 8'h01, 1'b0);  // v n h
   add_flag_case(4'd3, 8'hFF, 8'h01, 1'b0);  // c z h
   add_flag_case(4'd4, 8'h80, 8'h80, 1'b0);  // c v z
   add_flag_case(4'd4, 8'h3C, 8'hA5, 1'b1);  // n h with carry in
   add_flag_case(4'd5, 8'h0E, 8'h01, 1'b1);
   load_lit(4'd2, 8'h10);                    // dependent chain on one register
   for (int i = 0; i < 4; i++)
      add_lit(4'd2, 8'(8'h05 + i), 1'(i));
   add_entry(1'b1, {1'b1, 7'h00, 4'd2, 4'd3}, ADD, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 3'd0);
   read_pair(4'd3, 4'd2);
   for (int i = 0; i < 4; i++)
   begin
      add_entry(1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, banks[i]);
      load_lit(4'd0, 8'(8'h40 + i));
      load_lit(4'd1, 8'(8'hC0 + i));
      read_pair(4'd0, 4'd1);
      read_pair(4'd12, 4'd13);               // fixed codes, aliased by bank 6
   end
   // each bank again, its pair must still hold its own bytes
   for (int i = 0; i < 4; i++)
   begin
      add_entry(1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, banks[i]);
      read_pair(4'd0, 4'd1);
   end
   // bank load in the same cycle as a read keeps the old bank
   add_entry(1'b1, {1'b1, 7'h00, 4'd1, 4'd0}, PASS_B, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 3'd5);
   read_pair(4'd0, 4'd1);
   repeat (60)
   begin
      add_entry(($urandom % 8) != 0, 16'($urandom), 7'($urandom), 1'($urandom),
                1'($urandom), 1'($urandom), 1'($urandom), ($urandom % 6) == 0,
                3'($urandom));
   end
endtask

task automatic run_model();
   mcp1611_pkg::data_t    fa;
   mcp1611_pkg::data_t    fb;
   mcp1611_pkg::data_t    res;
   mcp1611_pkg::psw_t     fl;
   mcp1611_pkg::reg_idx_t ia;
   mcp1611_pkg::reg_idx_t ib;
   for (int i = 0; i < `MCP_REG_COUNT; i++)
      model_regs[i] = '0;
   model_bank = '0;
   model_psw  = '0;
   for (int k = 0; k < tbl.size(); k++)
   begin
      if (tbl[k].op_valid)
      begin
         ia = map_sel(tbl[k].mir[3:0], model_bank);
         ib = map_sel(tbl[k].mir[7:4], model_bank);
         fa = model_regs[ia];
         fb = tbl[k].mir[15] ? model_regs[ib] : tbl[k].mir[11:4];
         model_alu(fa, fb, tbl[k].fn, tbl[k].cin, res, fl);
         if (tbl[k].wr_en)
            model_regs[ia] = res;
         if (tbl[k].flag_we)
            model_psw = fl;
         tbl[k].exp_word = {fb, fa};
      end
      if (tbl[k].g_load)
         model_bank = tbl[k].g_data;         // after the op of the same entry
      tbl[k].exp_psw = model_psw;
   end
endtask

task automatic drive(input entry_t e);
   op_valid <= e.op_valid;
   mir      <= e.mir;
   alu_fn   <= e.fn;
   cin      <= e.cin;
   wr_en    <= e.wr_en;
   flag_we  <= e.flag_we;
   out_req  <= e.out_req;
   g_load   <= e.g_load;
   g_data   <= e.g_data;
endtask

// results of the op driven two edges ago
task automatic check_stage(input int k);
   check_flag("ad_stb", ad_stb, tbl[k].op_valid & tbl[k].out_req);
   check_psw("psw", psw, tbl[k].exp_psw);
   if (tbl[k].check)
      check_word("ad_out", ad_out, tbl[k].exp_word);
   if (UUT.u_assert.fail_count != 0)
   begin
      $display("a bound timing assertion on ad_stb or psw failed by %0t ns", $time);
      stop_on_error();
   end
endtask

initial
begin
   void'($urandom(88790));
   rst      = 1'b1;
   op_valid = 1'b0;
   mir      = '0;
   alu_fn   = '0;
   cin      = 1'b0;
   wr_en    = 1'b0;
   flag_we  = 1'b0;
   out_req  = 1'b0;
   g_load   = 1'b0;
   g_data   = '0;
   build_table();
   run_model();
   cycle_limit = 4 * tbl.size() + 50;
   limit_ready = 1'b1;
   repeat (5) @(posedge clk);
   rst <= 1'b0;
   @(negedge clk);
   check_flag("ad_stb", ad_stb, 1'b0);
   check_psw("psw", psw, '0);
   for (int j = 0; j < tbl.size() + 2; j++)
   begin
      @(posedge clk);
      if (j < tbl.size())
         drive(tbl[j]);
      else
      begin
         op_valid <= 1'b0;             // drain the pipeline
         g_load   <= 1'b0;
      end
      @(negedge clk);
      if (j >= 2)
         check_stage(j - 2);
   end
   if (err_count == 0)
   begin
      $display("Finished with no errors");
      $finish;
   end
   else
   begin
      $display("Finished with errors");
      $fatal(1, "run ended with failed checks");
   end
end

initial
begin
   wait (limit_ready);
   while (cycle_count < cycle_limit)
   begin
      @(posedge clk);
      cycle_count++;
   end
   $display("timeout: the table did not finish within %0d cycles", cycle_limit);
   $display("Finished with errors");
   $fatal(1, "run stopped by the cycle limit");
end

endmodule
